// File: hw/apu_settings.svh
`ifndef APU_SETTINGS_SVH
`define APU_SETTINGS_SVH

// Command queue
`define APU_FIFO_DEPTH 4

// Register file entries, 32 bits each
`define APU_NREGS 8

// APB address bus
`define APU_ADDR_W 8

// Queue level needs room for the full count
`define APU_LVL_W ($clog2(`APU_FIFO_DEPTH + 1))

`define APU_IDX_W ($clog2(`APU_NREGS))

`endif

// File: hw/apu_pkg.sv
`include "apu_settings.svh"

package apu_pkg;

	typedef struct packed {
		logic [3:0]  func;
		logic [1:0]  sz;
		logic        imm;      // Cleared in this form
		logic [2:0]  dst;
		logic [2:0]  src;
		logic [2:0]  arg;
		logic [15:0] rsvd;
	} apu_reg_form_t;

	typedef struct packed {
		logic [3:0]  func;
		logic [1:0]  sz;
		logic        imm;      // Set in this form
		logic [2:0]  dst;
		logic [2:0]  src;
		logic [2:0]  spare;
		logic [15:0] imm16;    // Replaces the arg register
	} apu_imm_form_t;

	typedef union packed {
		apu_reg_form_t r;
		apu_imm_form_t i;
	} apu_cmd_u;

	localparam logic [3:0] APU_F_LD  = 4'd0;
	localparam logic [3:0] APU_F_AND = 4'd1;
	localparam logic [3:0] APU_F_OR  = 4'd2;
	localparam logic [3:0] APU_F_XOR = 4'd3;
	localparam logic [3:0] APU_F_ADD = 4'd4;
	localparam logic [3:0] APU_F_SUB = 4'd5;
	localparam logic [3:0] APU_F_ADC = 4'd6;
	localparam logic [3:0] APU_F_SBC = 4'd7;
	localparam logic [3:0] APU_F_RL  = 4'd8;
	localparam logic [3:0] APU_F_RR  = 4'd9;
	localparam logic [3:0] APU_F_RLC = 4'd10;
	localparam logic [3:0] APU_F_RRC = 4'd11;
	localparam logic [3:0] APU_F_SRA = 4'd12;
	localparam logic [3:0] APU_F_SRZ = 4'd13;
	localparam logic [3:0] APU_F_NUL = 4'd14;
	localparam logic [3:0] APU_F_MUL = 4'd15;

	localparam logic [`APU_ADDR_W-1:0] APU_OFS_CMD    = 'h00;   // Write only
	localparam logic [`APU_ADDR_W-1:0] APU_OFS_STATUS = 'h04;   // Read only
	localparam logic [`APU_ADDR_W-1:0] APU_OFS_CTRL   = 'h08;
	localparam logic [`APU_ADDR_W-1:0] APU_OFS_REG    = 'h20;   // Register window base

endpackage

// File: hw/apu_cmd_port.sv
`timescale 1ns/1ps
`include "apu_settings.svh"

module apu_cmd_port import apu_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [`APU_ADDR_W-1:0] paddr,
	input  logic [31:0]            pwdata,
	output logic [31:0]            prdata,
	output logic                   pready,
	output logic                   pslverr,
	output logic                   push,
	output logic [31:0]            push_data,
	input  logic                   full,
	input  logic [`APU_LVL_W-1:0]  level,
	output logic                   run,
	input  logic                   busy,
	input  logic [3:0]             flags,
	output logic [`APU_IDX_W-1:0]  rd_idx,
	input  logic [31:0]            rd_data
);

	logic                   access;
	logic                   is_cmd;
	logic                   is_status;
	logic                   is_ctrl;
	logic                   is_reg;
	logic                   mapped;
	logic                   ro_write;
	logic                   cmd_refused;
	logic [`APU_ADDR_W-1:0] reg_ofs;

	assign access = psel & penable;     // APB access phase

	assign reg_ofs   = paddr - APU_OFS_REG;
	assign is_cmd    = (paddr == APU_OFS_CMD);
	assign is_status = (paddr == APU_OFS_STATUS);
	assign is_ctrl   = (paddr == APU_OFS_CTRL);
	assign is_reg    = (paddr >= APU_OFS_REG) &&
	                   (reg_ofs < `APU_ADDR_W'(4 * `APU_NREGS)) &&
	                   (paddr[1:0] == 2'b00);
	assign mapped    = is_cmd | is_status | is_ctrl | is_reg;

	assign ro_write    = pwrite & (is_status | is_reg);
	assign cmd_refused = pwrite & is_cmd & full;    // Queue full, word dropped

	assign pready  = 1'b1;
	assign pslverr = access & (~mapped | ro_write | cmd_refused);

	assign push      = access & pwrite & is_cmd & ~full;
	assign push_data = pwdata;

	assign rd_idx = reg_ofs[`APU_IDX_W+1:2];

	always_ff @(posedge clk) begin
		if (rst) begin
			run <= 1'b1;
		end else if (access && pwrite && is_ctrl) begin
			run <= pwdata[0];
		end
	end

	// Read mux, CMD reads back as zero
	always_comb begin
		prdata = '0;
		if (access && !pwrite) begin
			if (is_status) begin
				prdata[`APU_LVL_W-1:0] = level;
				prdata[4]              = busy;
				prdata[11:8]           = flags;     // Z S C V
			end else if (is_ctrl) begin
				prdata[0] = run;
			end else if (is_reg) begin
				prdata = rd_data;
			end
		end
	end

endmodule

// File: hw/apu_cmd_fifo.sv
`timescale 1ns/1ps
`include "apu_settings.svh"

module apu_cmd_fifo (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  push,
	input  logic [31:0]           push_data,
	input  logic                  pop,
	output logic [31:0]           pop_data,
	output logic                  empty,
	output logic                  full,
	output logic [`APU_LVL_W-1:0] level
);

	localparam int PTR_W = $clog2(`APU_FIFO_DEPTH);

	logic [31:0]      mem [`APU_FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;

	assign pop_data = mem[rd_ptr];      // Head word, fall-through
	assign empty    = (level == '0);
	assign full     = (level == `APU_LVL_W'(`APU_FIFO_DEPTH));

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(`APU_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(`APU_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;    // Push with pop keeps level
			endcase
		end
	end

endmodule

// File: hw/apu_alu.sv
`timescale 1ns/1ps

module apu_alu import apu_pkg::*; (
	input  logic [31:0] src,
	input  logic [31:0] arg,
	input  logic        c,
	input  logic [3:0]  func,
	input  logic [1:0]  sz,
	output logic [31:0] res,
	output logic        fz,
	output logic        fs,
	output logic        fc,
	output logic        fv
);

	logic [31:0] mask;
	logic [4:0]  msb;      // Top bit of the selected size
	logic [5:0]  w;        // Carry-out position
	logic [31:0] a;
	logic [31:0] b;
	logic        cin;
	logic [32:0] sum;
	logic [32:0] dif;
	logic [63:0] prod;
	logic [31:0] r;

	assign msb = {sz, 3'b111};
	assign w   = {1'b0, msb} + 6'd1;

	always_comb begin
		case (sz)
			2'b00:   mask = 32'h0000_00ff;
			2'b01:   mask = 32'h0000_ffff;
			2'b10:   mask = 32'h00ff_ffff;
			default: mask = 32'hffff_ffff;
		endcase
	end

	assign a   = src & mask;
	assign b   = arg & mask;
	assign cin = ((func == APU_F_ADC) || (func == APU_F_SBC)) ? c : 1'b0;

	assign sum  = {1'b0, a} + {1'b0, b} + 33'(cin);
	assign dif  = {1'b0, a} - {1'b0, b} - 33'(cin);    // Bit w is the borrow
	assign prod = {32'h0, a} * {32'h0, b};

	always_comb begin
		r  = '0;
		fc = 1'b0;
		fv = 1'b0;
		case (func)
			APU_F_LD:  r = b;      // Takes arg so an immediate can load
			APU_F_AND: r = a & b;
			APU_F_OR:  r = a | b;
			APU_F_XOR: r = a ^ b;
			APU_F_ADD, APU_F_ADC: begin
				r  = sum[31:0];
				fc = sum[w];
				fv = (a[msb] == b[msb]) && (sum[msb] != a[msb]);
			end
			APU_F_SUB, APU_F_SBC: begin
				r  = dif[31:0];
				fc = dif[w];
				fv = (a[msb] != b[msb]) && (dif[msb] != a[msb]);
			end
			APU_F_RL: begin
				r  = (a << 1) | {31'h0, a[msb]};
				fc = a[msb];
			end
			APU_F_RR: begin
				r  = (a >> 1) | ({31'h0, a[0]} << msb);
				fc = a[0];
			end
			APU_F_RLC: begin
				r  = (a << 1) | {31'h0, c};
				fc = a[msb];
			end
			APU_F_RRC: begin
				r  = (a >> 1) | ({31'h0, c} << msb);
				fc = a[0];
			end
			APU_F_SRA: begin
				r  = (a >> 1) | ({31'h0, a[msb]} << msb);
				fc = a[0];
			end
			APU_F_SRZ: begin
				r  = a >> 1;
				fc = a[0];
			end
			APU_F_NUL: r = '0;     // Never written back
			APU_F_MUL: begin
				r  = prod[31:0];
				fc = prod[w];      // First bit past the size
			end
		endcase
	end

	// Shift-out above the size is cut here
	assign res = r & mask;
	assign fz  = (res == '0);
	assign fs  = res[msb];

endmodule

// File: hw/apu_exec.sv
`timescale 1ns/1ps
`include "apu_settings.svh"

module apu_exec import apu_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  run,
	input  logic                  empty,
	input  logic [31:0]           pop_data,
	output logic                  pop,
	output logic                  busy,
	input  logic [`APU_IDX_W-1:0] rd_idx,
	output logic [31:0]           rd_data,
	output logic [3:0]            flags
);

	logic [31:0] regs [`APU_NREGS];
	apu_cmd_u    head;
	apu_cmd_u    cmd;
	logic        wb;        // Write-back state
	logic [31:0] src_q;
	logic [31:0] arg_q;
	logic [31:0] res;
	logic        fz;
	logic        fs;
	logic        fc;
	logic        fv;

	assign head = pop_data;

	// One command in flight, so no hazard on regs
	assign pop     = run & ~empty & ~wb;
	assign busy    = pop | wb;
	assign rd_data = regs[rd_idx];

	always_ff @(posedge clk) begin
		if (rst) begin
			wb <= 1'b0;
		end else begin
			wb <= pop;
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			cmd   <= head;
			src_q <= regs[head.r.src];
			arg_q <= head.r.imm ? {16'h0, head.i.imm16} : regs[head.r.arg];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `APU_NREGS; i++) begin
				regs[i] <= '0;
			end
			flags <= '0;
		end else if (wb && (cmd.r.func != APU_F_NUL)) begin
			regs[cmd.r.dst] <= res;
			flags           <= {fz, fs, fc, fv};
		end
	end

	apu_alu u_alu (
		.src  (src_q),
		.arg  (arg_q),
		.c    (flags[1]),      // Stored C
		.func (cmd.r.func),
		.sz   (cmd.r.sz),
		.res  (res),
		.fz   (fz),
		.fs   (fs),
		.fc   (fc),
		.fv   (fv)
	);

endmodule

// File: hw/apu_top.sv
`timescale 1ns/1ps
`include "apu_settings.svh"

module apu_top (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [`APU_ADDR_W-1:0] paddr,
	input  logic [31:0]            pwdata,
	output logic [31:0]            prdata,
	output logic                   pready,
	output logic                   pslverr
);

	logic                  push;
	logic [31:0]           push_data;
	logic                  full;
	logic                  empty;
	logic                  pop;
	logic [31:0]           pop_data;
	logic [`APU_LVL_W-1:0] level;
	logic                  run;
	logic                  busy;
	logic [3:0]            flags;
	logic [`APU_IDX_W-1:0] rd_idx;
	logic [31:0]           rd_data;

	apu_cmd_port u_port (
		.clk       (clk),
		.rst       (rst),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.push      (push),
		.push_data (push_data),
		.full      (full),
		.level     (level),
		.run       (run),
		.busy      (busy),
		.flags     (flags),
		.rd_idx    (rd_idx),
		.rd_data   (rd_data)
	);

	apu_cmd_fifo u_fifo (
		.clk       (clk),
		.rst       (rst),
		.push      (push),
		.push_data (push_data),
		.pop       (pop),
		.pop_data  (pop_data),
		.empty     (empty),
		.full      (full),
		.level     (level)
	);

	apu_exec u_exec (
		.clk      (clk),
		.rst      (rst),
		.run      (run),
		.empty    (empty),
		.pop_data (pop_data),
		.pop      (pop),
		.busy     (busy),
		.rd_idx   (rd_idx),
		.rd_data  (rd_data),
		.flags    (flags)
	);

endmodule

// File: verif/apu_chk.sv
`timescale 1ns/1ps

module apu_chk (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pslverr,
	input logic push,
	input logic full,
	input logic pop,
	input logic empty,
	input logic busy
);

	int fail_count = 0;    // Read by the testbench at the end

	a_slverr_phase: assert property (@(posedge clk) disable iff (rst)
		pslverr |-> psel && penable)
		else begin $error("pslverr raised outside an APB access phase"); fail_count++; end

	a_push_full: assert property (@(posedge clk) disable iff (rst) push |-> !full)
		else begin $error("push while the queue is full"); fail_count++; end

	a_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
		else begin $error("pop while the queue is empty"); fail_count++; end

	// Busy covers the pop cycle and the write-back cycle only
	a_busy_after_pop: assert property (@(posedge clk) disable iff (rst) pop |=> busy && !pop)
		else begin $error("busy not held for the write-back cycle"); fail_count++; end

	a_busy_source: assert property (@(posedge clk) disable iff (rst)
		busy && !pop |-> $past(pop))
		else begin $error("busy high without a pop in the cycle before"); fail_count++; end

	a_reset_quiet: assert property (@(posedge clk) rst |=> !push && !pop && !busy)
		else begin $error("push, pop or busy high right after reset"); fail_count++; end

endmodule

bind apu_top apu_chk u_chk (.*);

// File: verif/apu_tb.sv
`timescale 1ns/1ps
`include "apu_settings.svh"

module apu_tb import apu_pkg::*; ();

	logic                   clk;
	logic                   rst;
	logic                   psel;
	logic                   penable;
	logic                   pwrite;
	logic [`APU_ADDR_W-1:0] paddr;
	logic [31:0]            pwdata;
	logic [31:0]            prdata;
	logic                   pready;
	logic                   pslverr;

	integer      seed = 32'hce6cecb4;
	int          errors = 0;
	int          checks = 0;
	int          test_start = 0;
	logic [31:0] sh_regs [`APU_NREGS];    // Expected register file
	logic [3:0]  sh_flags;                // Expected Z S C V
	logic [31:0] rdata;
	logic        err;

	apu_top uut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] reg_word(input logic [3:0] f, input logic [1:0] sz,
			input logic [2:0] dst, input logic [2:0] src, input logic [2:0] arg);
		return {f, sz, 1'b0, dst, src, arg, 16'h0};
	endfunction

	function automatic logic [31:0] imm_word(input logic [3:0] f, input logic [1:0] sz,
			input logic [2:0] dst, input logic [15:0] imm16);
		return {f, sz, 1'b1, dst, 3'd0, 3'd0, imm16};
	endfunction

	// Expected {Z, S, C, V, result} of one command at n bits
	function automatic logic [35:0] alu_model(input logic [3:0] f, input logic [1:0] sz,
			input logic [31:0] x, input logic [31:0] y, input logic cf);
		int          n;
		logic [63:0] m;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] t;
		logic        ci;
		logic        c;
		logic        v;
		longint      sa;
		longint      sb;
		longint      sr;
		longint      lim;
		n   = 8 * (int'(sz) + 1);
		m   = (64'd1 << n) - 64'd1;
		a   = {32'h0, x} & m;
		b   = {32'h0, y} & m;
		lim = longint'(1) << (n - 1);
		sa  = a[n-1] ? longint'(a) - 2 * lim : longint'(a);    // Signed view
		sb  = b[n-1] ? longint'(b) - 2 * lim : longint'(b);
		ci  = ((f == APU_F_ADC) || (f == APU_F_SBC)) && cf;
		c   = 1'b0;
		v   = 1'b0;
		t   = '0;
		sr  = 0;
		case (f)
			APU_F_LD:  t = b;
			APU_F_AND: t = a & b;
			APU_F_OR:  t = a | b;
			APU_F_XOR: t = a ^ b;
			APU_F_ADD, APU_F_ADC: begin
				t  = a + b + 64'(ci);
				c  = t[n];
				sr = sa + sb + longint'(ci);
				v  = (sr >= lim) || (sr < -lim);
			end
			APU_F_SUB, APU_F_SBC: begin
				t  = a - b - 64'(ci);
				c  = (a < b + 64'(ci));    // Borrow
				sr = sa - sb - longint'(ci);
				v  = (sr >= lim) || (sr < -lim);
			end
			APU_F_RL: begin
				t = (a << 1) | (a >> (n - 1));
				c = a[n-1];
			end
			APU_F_RR: begin
				t = (a >> 1) | ((a & 64'd1) << (n - 1));
				c = a[0];
			end
			APU_F_RLC: begin
				t = (a << 1) | 64'(cf);
				c = a[n-1];
			end
			APU_F_RRC: begin
				t = (a >> 1) | (64'(cf) << (n - 1));
				c = a[0];
			end
			APU_F_SRA: begin
				t = (a >> 1) | (a & (64'd1 << (n - 1)));
				c = a[0];
			end
			APU_F_SRZ: begin
				t = a >> 1;
				c = a[0];
			end
			APU_F_MUL: begin
				t = a * b;
				c = t[n];
			end
			default:   t = '0;
		endcase
		t = t & m;
		return {(t == 64'd0), t[n-1], c, v, t[31:0]};
	endfunction

	task automatic expect_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	// Setup phase then access phase with outputs sampled mid-access
	task automatic transfer(input logic wr, input logic [`APU_ADDR_W-1:0] addr,
			input logic [31:0] wdata, output logic [31:0] rd, output logic e);
		@(posedge clk);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge clk);
		#1;
		penable = 1'b1;
		@(negedge clk);
		rd = prdata;
		e  = pslverr;
		expect_value("pready", 32'(pready), 32'd1);
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic wait_idle();
		logic [31:0] st;
		logic        e;
		int          tries;
		tries = 0;
		do begin
			transfer(1'b0, APU_OFS_STATUS, 32'h0, st, e);
			tries++;
		end while ((st[4] || st[2:0] != 3'd0) && tries < 100);
		if (st[4] || st[2:0] != 3'd0) begin
			$display("Timed out after %0d polls waiting for the APU to go idle", tries);
			$display("Checks: %0d, errors: %0d", checks, errors + 1);
			$display("Finished with errors");
			$finish;
		end
	endtask

	// Push a command and advance the expected state unless it should be refused
	task automatic send_cmd(input logic [31:0] w, input logic exp_err);
		logic [31:0] y;
		logic [35:0] r;
		transfer(1'b1, APU_OFS_CMD, w, rdata, err);
		expect_value("pslverr", 32'(err), 32'(exp_err));
		if (!exp_err && w[31:28] != APU_F_NUL) begin
			y = w[25] ? {16'h0, w[15:0]} : sh_regs[w[18:16]];
			r = alu_model(w[31:28], w[27:26], sh_regs[w[21:19]], y, sh_flags[1]);
			sh_regs[w[24:22]] = r[31:0];
			sh_flags          = r[35:32];
		end
	endtask

	task automatic verify_state();
		for (int i = 0; i < `APU_NREGS; i++) begin
			transfer(1'b0, APU_OFS_REG + `APU_ADDR_W'(4 * i), 32'h0, rdata, err);
			expect_value($sformatf("r%0d", i), rdata, sh_regs[i]);
		end
		transfer(1'b0, APU_OFS_STATUS, 32'h0, rdata, err);
		expect_value("status", rdata, {20'h0, sh_flags, 8'h00});
	endtask

	task automatic exec_cmd(input logic [31:0] w);
		send_cmd(w, 1'b0);
		wait_idle();
		verify_state();
	endtask

	// Builds a 32-bit value through scratch r6 and r7 with two multiplies
	task automatic load_wide(input logic [2:0] dst, input logic [31:0] val);
		send_cmd(imm_word(APU_F_LD, 2'd3, 3'd6, val[31:16]), 1'b0);
		send_cmd(imm_word(APU_F_LD, 2'd3, 3'd7, 16'h0100), 1'b0);
		send_cmd(reg_word(APU_F_MUL, 2'd3, 3'd6, 3'd6, 3'd7), 1'b0);
		send_cmd(reg_word(APU_F_MUL, 2'd3, 3'd6, 3'd6, 3'd7), 1'b0);
		send_cmd(imm_word(APU_F_LD, 2'd3, 3'd7, val[15:0]), 1'b0);
		send_cmd(reg_word(APU_F_OR, 2'd3, dst, 3'd6, 3'd7), 1'b0);
		wait_idle();
	endtask

	task automatic end_test(input int n, input string name);
		$display("Test %0d %s: %0d errors", n, name, errors - test_start);
		test_start = errors;
	endtask

	initial begin
		rst      = 1'b1;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		paddr    = '0;
		pwdata   = '0;
		sh_flags = '0;
		for (int i = 0; i < `APU_NREGS; i++) begin
			sh_regs[i] = '0;
		end
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		verify_state();

		exec_cmd(imm_word(APU_F_LD, 2'd3, 3'd1, 16'hf0f0));
		exec_cmd(imm_word(APU_F_LD, 2'd3, 3'd2, 16'h3cc3));
		for (int s = 0; s < 4; s++) begin
			exec_cmd(reg_word(APU_F_SUB, 2'd1, 3'd0, 3'd2, 3'd1));    // Sets C first
			exec_cmd(reg_word(APU_F_AND, 2'(s), 3'd3, 3'd1, 3'd2));
			exec_cmd(reg_word(APU_F_OR, 2'(s), 3'd4, 3'd1, 3'd2));
			exec_cmd(reg_word(APU_F_XOR, 2'(s), 3'd5, 3'd1, 3'd1));  // Zero
		end
		end_test(1, "load and logic");

		for (int s = 0; s < 4; s++) begin
			load_wide(3'd1, $random(seed));
			load_wide(3'd2, $random(seed));
			exec_cmd(reg_word(APU_F_ADD, 2'(s), 3'd3, 3'd1, 3'd2));
			exec_cmd(reg_word(APU_F_SUB, 2'(s), 3'd4, 3'd1, 3'd2));
			exec_cmd(reg_word(APU_F_ADC, 2'(s), 3'd5, 3'd1, 3'd2));
			exec_cmd(reg_word(APU_F_SBC, 2'(s), 3'd3, 3'd2, 3'd1));
			exec_cmd(reg_word(APU_F_ADD, 2'(s), 3'd4, 3'd1, 3'd1));
		end
		end_test(2, "add and subtract");

		for (int s = 0; s < 4; s++) begin
			load_wide(3'd1, $random(seed));
			for (int f = 8; f < 14; f++) begin
				exec_cmd(reg_word(4'(f), 2'(s), 3'd2, 3'd1, 3'd0));
			end
		end
		end_test(3, "rotate and shift");

		exec_cmd(imm_word(APU_F_LD, 2'd3, 3'd1, 16'h0080));
		exec_cmd(imm_word(APU_F_LD, 2'd3, 3'd2, 16'h0003));
		exec_cmd(reg_word(APU_F_MUL, 2'd0, 3'd3, 3'd1, 3'd2));     // Carry out of byte
		for (int s = 0; s < 4; s++) begin
			load_wide(3'd1, $random(seed));
			load_wide(3'd2, $random(seed));
			exec_cmd(reg_word(APU_F_MUL, 2'(s % 2), 3'd3, 3'd1, 3'd2));
		end
		end_test(4, "multiply");

		transfer(1'b1, APU_OFS_CTRL, 32'h0, rdata, err);
		expect_value("pslverr", 32'(err), 32'd0);
		for (int i = 0; i < 5; i++) begin
			send_cmd(imm_word(APU_F_LD, 2'd3, 3'(i), 16'h1000 + 16'(i)), i == 4);
		end
		transfer(1'b0, APU_OFS_STATUS, 32'h0, rdata, err);
		expect_value("level", 32'(rdata[2:0]), 32'd4);
		transfer(1'b1, APU_OFS_CTRL, 32'h1, rdata, err);
		wait_idle();
		verify_state();
		end_test(5, "back-pressure");

		exec_cmd(reg_word(APU_F_SUB, 2'd0, 3'd0, 3'd0, 3'd1));     // Sets S and C
		exec_cmd(imm_word(APU_F_NUL, 2'd3, 3'd0, 16'hffff));
		transfer(1'b0, 8'h40, 32'h0, rdata, err);
		expect_value("pslverr", 32'(err), 32'd1);
		transfer(1'b1, 8'h10, 32'h0, rdata, err);
		expect_value("pslverr", 32'(err), 32'd1);
		transfer(1'b1, APU_OFS_STATUS, 32'hffff_ffff, rdata, err);
		expect_value("pslverr", 32'(err), 32'd1);
		transfer(1'b1, APU_OFS_REG + 8'h04, 32'h1234_5678, rdata, err);
		expect_value("pslverr", 32'(err), 32'd1);
		transfer(1'b0, APU_OFS_CTRL, 32'h0, rdata, err);
		expect_value("ctrl", rdata, 32'h1);
		verify_state();
		end_test(6, "no-op and bus errors");

		errors = errors + uut.u_chk.fail_count;
		$display("Tests: 6, checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// File: filelist.f
+incdir+hw
hw/apu_pkg.sv
hw/apu_cmd_port.sv
hw/apu_cmd_fifo.sv
hw/apu_alu.sv
hw/apu_exec.sv
hw/apu_top.sv
verif/apu_chk.sv
verif/apu_tb.sv

// File: Bender.yml
package:
  name: apu

sources:
  - include_dirs:
      - hw
    files:
      - hw/apu_pkg.sv
      - hw/apu_cmd_port.sv
      - hw/apu_cmd_fifo.sv
      - hw/apu_alu.sv
      - hw/apu_exec.sv
      - hw/apu_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/apu_chk.sv
      - verif/apu_tb.sv
